// ==== src.f ====
hex_console_pkg.sv
hex_formatter.sv
char_fifo.sv
uart_tx.sv
uart_rx.sv
hex_console_top.sv
tb_hex_console_top.sv

// ==== Bender.yml ====
package:
  name: hex_console

sources:
  - hex_console_pkg.sv
  - hex_formatter.sv
  - char_fifo.sv
  - uart_tx.sv
  - uart_rx.sv
  - hex_console_top.sv
  - target: test
    files:
      - tb_hex_console_top.sv

// ==== tb_hex_console_top.sv ====
module tb_hex_console_top import hex_console_pkg::*; ();

   localparam int CLKS_PER_BIT   = 8;
   localparam int FIFO_DEPTH     = 4;
   localparam int CLK_PERIOD     = 20;
   localparam int BIT_T          = CLKS_PER_BIT * CLK_PERIOD;
   localparam int FRAME_T        = 10 * BIT_T;
   localparam int CHARS_PER_WORD = NUM_NIB + 2;        // Digits, LF, CR
   localparam int NUM_TESTS      = 6;
   localparam int NUM_RX         = 7;
   localparam int NUM_CHARS      = 2 * NUM_TESTS * CHARS_PER_WORD;  // Two transmit passes
   localparam int WATCHDOG_T     = 2 * (NUM_CHARS * FRAME_T + NUM_RX * FRAME_T);

   logic  clk = 1'b0;
   logic  rst;
   word_t i_tx_data;
   logic  i_tx_stb;
   logic  i_rx;
   logic  o_tx;
   logic  o_tx_busy;
   char_t o_rx_data;
   logic  o_rx_valid;

   string test_name [NUM_TESTS];
   word_t test_word [NUM_TESTS];
   char_t rx_byte [NUM_RX] = '{8'h55, 8'hA3, 8'h00, 8'hFF, 8'h3C, 8'h81, 8'hE7};
   logic  rx_good [NUM_RX] = '{1'b1, 1'b1, 1'b1, 1'b0, 1'b1, 1'b0, 1'b1};  // Stop bit high

   char_t tx_decoded [$];   // Bytes seen on o_tx
   char_t exp_chars [$];
   string exp_names [$];
   char_t rx_got [$];       // Bytes flagged by o_rx_valid

   int check_cnt    = 0;
   int mismatch_cnt = 0;
   int fail_cnt     = 0;

   hex_console_top #(
      .CLKS_PER_BIT (CLKS_PER_BIT),
      .FIFO_DEPTH   (FIFO_DEPTH)
   ) UUT (
      .clk        (clk),
      .rst        (rst),
      .i_tx_data  (i_tx_data),
      .i_tx_stb   (i_tx_stb),
      .i_rx       (i_rx),
      .o_tx       (o_tx),
      .o_tx_busy  (o_tx_busy),
      .o_rx_data  (o_rx_data),
      .o_rx_valid (o_rx_valid)
   );

   always #(CLK_PERIOD/2) clk = ~clk;

   function automatic char_t hex_digit(input logic [3:0] nib);
      string digits = "0123456789ABCDEF";
      return char_t'(digits[nib]);
   endfunction

   // Expected upper-case line for one word in MSB-first nibble order
   task automatic push_expected(input string name, input word_t w);
      for (int n = NUM_NIB - 1; n >= 0; n--)
      begin
         exp_chars.push_back(hex_digit(w[n*4 +: 4]));
         exp_names.push_back(name);
      end
      exp_chars.push_back(CHAR_LF);
      exp_names.push_back(name);
      exp_chars.push_back(CHAR_CR);
      exp_names.push_back(name);
   endtask

   task automatic compare_char(input string name, input char_t exp, input char_t act);
      check_cnt++;
      assert (act === exp)
      else
      begin
         $display("MISMATCH %s: expected %h, actual %h", name, exp, act);
         mismatch_cnt++;
      end
   endtask

   task automatic expect_level(input string name, input logic exp, input logic act);
      check_cnt++;
      assert (act === exp)
      else
      begin
         $display("MISMATCH %s: expected %b, actual %b", name, exp, act);
         mismatch_cnt++;
      end
   endtask

   task automatic strobe_word(input word_t w);
      i_tx_data = w;
      i_tx_stb  = 1'b1;
      @(negedge clk);
      i_tx_stb  = 1'b0;
   endtask

   task automatic wait_idle();
      while (o_tx_busy)
         @(negedge clk);
   endtask

   task automatic wait_chars(input int n);
      while (tx_decoded.size() < n)
         @(negedge clk);
   endtask

   // Pops every expected character against the decoded stream
   task automatic match_stream();
      while (exp_chars.size() > 0)
         compare_char(exp_names.pop_front(), exp_chars.pop_front(), tx_decoded.pop_front());
   endtask

   task automatic send_frame(input char_t b, input logic stop_bit);
      i_rx = 1'b0;
      repeat (CLKS_PER_BIT) @(negedge clk);
      for (int k = 0; k < 8; k++)
      begin
         i_rx = b[k];  // LSB first
         repeat (CLKS_PER_BIT) @(negedge clk);
      end
      i_rx = stop_bit;
      repeat (CLKS_PER_BIT) @(negedge clk);
      i_rx = 1'b1;
   endtask

   // Serial decoder sampling each bit a quarter clock past its middle
   initial
   begin : tx_decoder
      char_t b;
      wait (rst === 1'b0);
      forever
      begin
         @(negedge o_tx);
         #(BIT_T/2 + CLK_PERIOD/4);
         check_cnt++;
         assert (o_tx == 1'b0)
         else
         begin
            $display("ERROR: start bit on o_tx not low at mid-bit, time %0t", $time);
            fail_cnt++;
         end
         if (o_tx == 1'b0)
         begin
            for (int k = 0; k < 8; k++)
            begin
               #(BIT_T);
               b[k] = o_tx;
            end
            #(BIT_T);
            check_cnt++;
            assert (o_tx == 1'b1)
            else
            begin
               $display("ERROR: stop bit on o_tx not high, time %0t", $time);
               fail_cnt++;
            end
            tx_decoded.push_back(b);
         end
      end
   end

   always @(negedge clk)
   begin
      if (rst === 1'b0 && o_rx_valid === 1'b1)
         rx_got.push_back(o_rx_data);
   end

   initial
   begin : watchdog
      #(WATCHDOG_T);
      $display("ERROR: run timed out after %0d time units", WATCHDOG_T);
      $display("Checks: %0d, mismatches: %0d, other errors: %0d",
               check_cnt, mismatch_cnt, fail_cnt + 1);
      $display("TEST FAILED");
      $finish;
   end

   initial
   begin : main
      string name;
      void'($urandom(29));
      rst       = 1'b1;
      i_tx_data = '0;
      i_tx_stb  = 1'b0;
      i_rx      = 1'b1;  // Line idles high

      test_name[0] = "zeros";
      test_word[0] = 16'h0000;
      test_name[1] = "ones";
      test_word[1] = 16'hFFFF;
      test_name[2] = "count";
      test_word[2] = 16'h1234;
      test_name[3] = "mixed";
      test_word[3] = 16'hA5C3;
      test_name[4] = "rand0";
      test_word[4] = word_t'($urandom());
      test_name[5] = "rand1";
      test_word[5] = word_t'($urandom());

      repeat (4) @(negedge clk);
      rst = 1'b0;
      @(negedge clk);
      expect_level("reset o_tx", 1'b1, o_tx);
      expect_level("reset o_tx_busy", 1'b0, o_tx_busy);
      expect_level("reset o_rx_valid", 1'b0, o_rx_valid);

      // One word at a time with each line checked on its own
      for (int i = 0; i < NUM_TESTS; i++)
      begin
         wait_idle();
         strobe_word(test_word[i]);
         expect_level({test_name[i], " busy"}, 1'b1, o_tx_busy);
         push_expected(test_name[i], test_word[i]);
         wait_chars(CHARS_PER_WORD);
         match_stream();
      end

      // Back-to-back words fill the FIFO and stall the formatter
      for (int i = 0; i < NUM_TESTS; i++)
      begin
         name = $sformatf("b2b_%s", test_name[i]);
         wait_idle();
         strobe_word(test_word[i]);
         expect_level({name, " busy"}, 1'b1, o_tx_busy);
         push_expected(name, test_word[i]);
         strobe_word(~test_word[i]);  // Lands while busy
      end
      wait_chars(NUM_TESTS * CHARS_PER_WORD);
      match_stream();
      repeat (2 * 10 * CLKS_PER_BIT) @(negedge clk);
      check_cnt++;
      assert (tx_decoded.size() == 0)
      else
      begin
         $display("ERROR: %0d unexpected extra characters on o_tx", tx_decoded.size());
         fail_cnt++;
      end

      for (int i = 0; i < NUM_RX; i++)
      begin
         name = $sformatf("rx_%0d", i);
         send_frame(rx_byte[i], rx_good[i]);
         repeat (2 * CLKS_PER_BIT) @(negedge clk);
         check_cnt++;
         if (rx_good[i])
         begin
            assert (rx_got.size() == 1)
            else
            begin
               $display("ERROR: %s expected one o_rx_valid pulse, saw %0d", name, rx_got.size());
               fail_cnt++;
            end
            if (rx_got.size() > 0)
               compare_char(name, rx_byte[i], rx_got[0]);
         end
         else
         begin
            assert (rx_got.size() == 0)
            else
            begin
               $display("ERROR: %s pulsed o_rx_valid despite a low stop bit", name);
               fail_cnt++;
            end
         end
         rx_got.delete();
      end

      $display("Checks: %0d, mismatches: %0d, other errors: %0d",
               check_cnt, mismatch_cnt, fail_cnt);
      if (mismatch_cnt == 0 && fail_cnt == 0)
         $display("TEST PASSED");
      else
         $display("TEST FAILED");
      $finish;
   end

endmodule

// ==== hex_console_top.sv ====
module hex_console_top import hex_console_pkg::*; #(
   parameter int CLKS_PER_BIT = 16,
   parameter int FIFO_DEPTH   = 4
) (
   input  logic  clk,
   input  logic  rst,
   input  word_t i_tx_data,
   input  logic  i_tx_stb,
   input  logic  i_rx,
   output logic  o_tx,
   output logic  o_tx_busy,
   output char_t o_rx_data,
   output logic  o_rx_valid
);

   char_t fmt_char;
   logic  fmt_wr;
   logic  fifo_full;
   logic  fifo_empty;
   char_t fifo_data;
   logic  fifo_rd;
   logic  fifo_rd_z;   // Delayed read, starts the frame
   char_t tx_byte;
   logic  tx_active;

   hex_formatter u_formatter (
      .clk         (clk),
      .rst         (rst),
      .i_tx_data   (i_tx_data),
      .i_tx_stb    (i_tx_stb),
      .i_fifo_full (fifo_full),
      .o_char      (fmt_char),
      .o_char_wr   (fmt_wr),
      .o_busy      (o_tx_busy)
   );

   char_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_fifo (
      .clk     (clk),
      .rst     (rst),
      .i_data  (fmt_char),
      .i_wr    (fmt_wr),
      .i_rd    (fifo_rd),
      .o_data  (fifo_data),
      .o_full  (fifo_full),
      .o_empty (fifo_empty)
   );

   // One read per frame; the delay term covers the cycle before tx_active rises
   assign fifo_rd = !fifo_empty && !tx_active && !fifo_rd_z;

   always_ff @(posedge clk)
   begin
      if (rst)
         fifo_rd_z <= 1'b0;
      else
         fifo_rd_z <= fifo_rd;
   end

   always_ff @(posedge clk)
   begin
      if (fifo_rd)
         tx_byte <= fifo_data;  // Head byte before the pointer moves on
   end

   uart_tx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_tx (
      .clk      (clk),
      .rst      (rst),
      .i_start  (fifo_rd_z),
      .i_byte   (tx_byte),
      .o_tx     (o_tx),
      .o_active (tx_active)
   );

   uart_rx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_rx (
      .clk     (clk),
      .rst     (rst),
      .i_rx    (i_rx),
      .o_byte  (o_rx_data),
      .o_valid (o_rx_valid)
   );

endmodule

// ==== uart_rx.sv ====
module uart_rx import hex_console_pkg::*; #(
   parameter int CLKS_PER_BIT = 16
) (
   input  logic  clk,
   input  logic  rst,
   input  logic  i_rx,
   output char_t o_byte,
   output logic  o_valid
);

   localparam int CNT_W = $clog2(CLKS_PER_BIT);
   localparam logic [CNT_W-1:0] LAST_CLK = CNT_W'(CLKS_PER_BIT - 1);
   localparam logic [CNT_W-1:0] HALF_CLK = CNT_W'(CLKS_PER_BIT / 2 - 1);

   rx_state_e        state;
   logic             rx_meta;
   logic             rx_sync;
   logic             rx_prev;   // For falling edge detection
   logic [CNT_W-1:0] clk_cnt;
   logic [2:0]       bit_idx;
   char_t            shreg;

   // Two-flop synchronizer, idles high
   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         rx_meta <= 1'b1;
         rx_sync <= 1'b1;
         rx_prev <= 1'b1;
      end
      else
      begin
         rx_meta <= i_rx;
         rx_sync <= rx_meta;
         rx_prev <= rx_sync;
      end
   end

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         state   <= RX_IDLE;
         clk_cnt <= '0;
         bit_idx <= '0;
         o_valid <= 1'b0;
      end
      else
      begin
         o_valid <= 1'b0;
         case (state)
            RX_IDLE:
               if (rx_prev && !rx_sync)
               begin
                  state   <= RX_START;
                  clk_cnt <= '0;
               end
            RX_START:
               if (clk_cnt == HALF_CLK)
               begin
                  clk_cnt <= '0;
                  bit_idx <= '0;
                  state   <= rx_sync ? RX_IDLE : RX_DATA;  // High again means glitch
               end
               else
                  clk_cnt <= clk_cnt + 1'b1;
            RX_DATA:
               if (clk_cnt == LAST_CLK)
               begin
                  clk_cnt <= '0;
                  bit_idx <= bit_idx + 1'b1;
                  if (bit_idx == 3'd7)
                     state <= RX_STOP;
               end
               else
                  clk_cnt <= clk_cnt + 1'b1;
            RX_STOP:
               if (clk_cnt == LAST_CLK)
               begin
                  o_valid <= rx_sync;  // Bad stop bit drops the frame
                  state   <= RX_IDLE;
               end
               else
                  clk_cnt <= clk_cnt + 1'b1;
            default:
               state <= RX_IDLE;
         endcase
      end
   end

   // Mid-bit sample, LSB first
   always_ff @(posedge clk)
   begin
      if (state == RX_DATA && clk_cnt == LAST_CLK)
         shreg <= {rx_sync, shreg[7:1]};
   end

   assign o_byte = shreg;

   a_valid_pulse: assert property (@(posedge clk) disable iff (rst) o_valid |=> !o_valid);

endmodule

// ==== uart_tx.sv ====
module uart_tx import hex_console_pkg::*; #(
   parameter int CLKS_PER_BIT = 16
) (
   input  logic  clk,
   input  logic  rst,
   input  logic  i_start,
   input  char_t i_byte,
   output logic  o_tx,
   output logic  o_active
);

   localparam int CNT_W = $clog2(CLKS_PER_BIT);
   localparam logic [CNT_W-1:0] LAST_CLK = CNT_W'(CLKS_PER_BIT - 1);

   tx_state_e        state;
   logic [CNT_W-1:0] clk_cnt;   // Cycles within the current bit
   logic [2:0]       bit_idx;
   char_t            shreg;

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         state   <= TX_IDLE;
         clk_cnt <= '0;
         bit_idx <= '0;
      end
      else
      begin
         case (state)
            TX_IDLE:
               if (i_start)
               begin
                  state   <= TX_START;
                  clk_cnt <= '0;
               end
            TX_START:
               if (clk_cnt == LAST_CLK)
               begin
                  state   <= TX_DATA;
                  clk_cnt <= '0;
                  bit_idx <= '0;
               end
               else
                  clk_cnt <= clk_cnt + 1'b1;
            TX_DATA:
               if (clk_cnt == LAST_CLK)
               begin
                  clk_cnt <= '0;
                  bit_idx <= bit_idx + 1'b1;
                  if (bit_idx == 3'd7)
                     state <= TX_STOP;
               end
               else
                  clk_cnt <= clk_cnt + 1'b1;
            TX_STOP:
               if (clk_cnt == LAST_CLK)
                  state <= TX_IDLE;
               else
                  clk_cnt <= clk_cnt + 1'b1;
            default:
               state <= TX_IDLE;
         endcase
      end
   end

   // Byte latch and LSB-first shift
   always_ff @(posedge clk)
   begin
      if (state == TX_IDLE && i_start)
         shreg <= i_byte;
      else if (state == TX_DATA && clk_cnt == LAST_CLK)
         shreg <= {1'b0, shreg[7:1]};
   end

   always_comb
   begin
      case (state)
         TX_START: o_tx = 1'b0;
         TX_DATA:  o_tx = shreg[0];
         default:  o_tx = 1'b1;  // Idle and stop are mark level
      endcase
   end

   assign o_active = (state != TX_IDLE);

   // Read pacing in the top level must keep starts out of a running frame
   a_no_start_active: assert property (@(posedge clk) disable iff (rst)
      !(i_start && o_active));

endmodule

// ==== char_fifo.sv ====
module char_fifo import hex_console_pkg::*; #(
   parameter int FIFO_DEPTH = 4
) (
   input  logic  clk,
   input  logic  rst,
   input  char_t i_data,
   input  logic  i_wr,
   input  logic  i_rd,
   output char_t o_data,
   output logic  o_full,
   output logic  o_empty
);

   localparam int PTR_W = $clog2(FIFO_DEPTH);

   char_t            mem [FIFO_DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [PTR_W:0]   count;     // Occupancy, one bit wider than the pointers
   logic             do_wr;
   logic             do_rd;

   assign do_wr = i_wr && !o_full;
   assign do_rd = i_rd && !o_empty;

   always_ff @(posedge clk)
   begin
      if (do_wr)
         mem[wr_ptr] <= i_data;
   end

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (do_wr)
            wr_ptr <= wr_ptr + 1'b1;  // Wraps, depth is a power of two
         if (do_rd)
            rd_ptr <= rd_ptr + 1'b1;
         case ({do_wr, do_rd})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   assign o_data  = mem[rd_ptr];  // Head entry
   assign o_full  = (count == (PTR_W+1)'(FIFO_DEPTH));
   assign o_empty = (count == '0);

   a_no_wr_full: assert property (@(posedge clk) disable iff (rst) !(i_wr && o_full));
   a_no_rd_empty: assert property (@(posedge clk) disable iff (rst) !(i_rd && o_empty));

endmodule

// ==== hex_formatter.sv ====
module hex_formatter import hex_console_pkg::*; (
   input  logic  clk,
   input  logic  rst,
   input  word_t i_tx_data,
   input  logic  i_tx_stb,
   input  logic  i_fifo_full,
   output char_t o_char,
   output logic  o_char_wr,
   output logic  o_busy
);

   localparam int CNT_W = (NUM_NIB > 1) ? $clog2(NUM_NIB) : 1;
   localparam logic [CNT_W-1:0] LAST_NIB = CNT_W'(NUM_NIB - 1);

   fmt_state_e       state;
   word_t            word_q;    // Top nibble is the next digit
   logic [CNT_W-1:0] nib_cnt;

   function automatic char_t nib_to_ascii(input logic [3:0] nib);
      char_t c;
      if (nib < 4'd10)
         c = CHAR_0 + char_t'(nib);
      else
         c = CHAR_A + char_t'(nib - 4'd10);
      return c;
   endfunction

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         state   <= FMT_IDLE;
         nib_cnt <= '0;
      end
      else
      begin
         case (state)
            FMT_IDLE:
               if (i_tx_stb)
               begin
                  state   <= FMT_NIB;
                  nib_cnt <= '0;
               end
            FMT_NIB:
               if (!i_fifo_full)
               begin
                  if (nib_cnt == LAST_NIB)
                     state <= FMT_LF;
                  nib_cnt <= nib_cnt + 1'b1;
               end
            FMT_LF:
               if (!i_fifo_full)
                  state <= FMT_CR;
            FMT_CR:
               if (!i_fifo_full)
                  state <= FMT_IDLE;
            default:
               state <= FMT_IDLE;
         endcase
      end
   end

   // Word capture and nibble shift
   always_ff @(posedge clk)
   begin
      if (state == FMT_IDLE && i_tx_stb)
         word_q <= i_tx_data;
      else if (state == FMT_NIB && !i_fifo_full)
         word_q <= {word_q[DP_WIDTH-5:0], 4'h0};
   end

   always_comb
   begin
      case (state)
         FMT_LF:  o_char = CHAR_LF;
         FMT_CR:  o_char = CHAR_CR;
         default: o_char = nib_to_ascii(word_q[DP_WIDTH-1 -: 4]);
      endcase
   end

   assign o_char_wr = (state != FMT_IDLE) && !i_fifo_full;  // Stall holds the character
   assign o_busy    = (state != FMT_IDLE);

   // Full FIFO freezes the state and the held character
   a_stall_hold: assert property (@(posedge clk) disable iff (rst)
      (o_busy && i_fifo_full) |=> (o_busy && $stable(o_char)));

endmodule

// ==== hex_console_pkg.sv ====
package hex_console_pkg;

   // Parallel word width, must be a multiple of 4
   localparam int DP_WIDTH = 16;
   localparam int NUM_NIB  = DP_WIDTH / 4;  // Hex digits per word

   typedef logic [DP_WIDTH-1:0] word_t;
   typedef logic [7:0]          char_t;     // ASCII character or UART byte

   // ASCII codes
   localparam char_t CHAR_LF = 8'h0A;
   localparam char_t CHAR_CR = 8'h0D;
   localparam char_t CHAR_0  = 8'h30;
   localparam char_t CHAR_A  = 8'h41;

   typedef enum logic [1:0] {
      FMT_IDLE,
      FMT_NIB,
      FMT_LF,
      FMT_CR
   } fmt_state_e;

   typedef enum logic [1:0] {
      TX_IDLE,
      TX_START,
      TX_DATA,
      TX_STOP
   } tx_state_e;

   typedef enum logic [1:0] {
      RX_IDLE,
      RX_START,
      RX_DATA,
      RX_STOP
   } rx_state_e;

endpackage
